// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build tb_soc_dbus with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_soc_dbus -f files.f --Mdir obj_dir -o tb_soc_dbus
	./obj_dir/tb_soc_dbus | tee $(LOG)
	@grep -q "Done: no errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== files.f ====
+incdir+include
source/soc_pkg.sv
source/chip_select.sv
source/ram_arb.sv
source/sp_ram.sv
source/gpio.sv
source/timer.sv
source/irq_reg.sv
source/soc_dbus.sv
test/tb_soc_dbus.sv

// ==== include/soc_cfg.svh ====
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus widths
`define SOC_ADDR_BITS   32
`define SOC_DATA_BITS   32

// Device field is the top byte of the address
`define SOC_DEV_BITS    8

// Device addresses, compared against addr[31:24]
`define SOC_RAM_ADDR    8'h00
`define SOC_GPIO_ADDR   8'h40
`define SOC_IRQ_ADDR    8'h80
`define SOC_TIMER_ADDR  8'hc0

// RAM depth in 32-bit words
`define SOC_RAM_WORDS   256

// Timer at bit 0, external source at bit 1
`define SOC_IRQ_SOURCES 2

`endif

// ==== source/chip_select.sv ====
module chip_select
    import soc_pkg::*;
#(
    parameter dev_id_t ADDR = '0
) (
    input  logic    ck,
    input  logic    RESET_LOOP,
    input  logic    i_cyc,
    input  dev_id_t i_dev,
    output logic    o_sel,
    output logic    o_ack
);

    logic match;

    // Cycle open and aimed at this device
    assign match = i_cyc && (i_dev == ADDR);
    assign o_sel = match;

    // One-cycle ack, then held off for a cycle while the master
    // still has cyc up
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= match && !o_ack;
        end
    end

    // A held cycle must never be acknowledged twice
    a_ack_single: assert property (
        @(posedge ck) disable iff (RESET_LOOP)
        o_ack |=> !o_ack
    );

endmodule

// ==== source/gpio.sv ====
module gpio
    import soc_pkg::*;
(
    input  logic       ck,
    input  logic       RESET_LOOP,
    input  logic       i_sel,
    input  logic       i_ack,
    input  dbus_req_t  i_req,
    output dbus_rsp_t  o_rsp,
    output logic [7:0] o_gpio
);

    logic [7:0] gpio_q;
    logic       wr;

    // Only lane 0 carries the output byte
    assign wr = i_sel && i_ack && i_req.we && i_req.sel[0];

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            gpio_q <= '0;
        end else if (wr) begin
            gpio_q <= i_req.dat[7:0];
        end
    end

    assign o_gpio = gpio_q;

    // Read-back zero-extended, quiet outside the ack cycle
    assign o_rsp.ack = i_ack;
    assign o_rsp.rdt = i_ack ? bus_data_t'(gpio_q) : '0;

endmodule

// ==== source/irq_reg.sv ====
module irq_reg
    import soc_pkg::*;
#(
    parameter int NUM_IRQ = 2
) (
    input  logic               ck,
    input  logic               RESET_LOOP,
    input  logic               i_sel,
    input  logic               i_ack,
    input  dbus_req_t          i_req,
    output dbus_rsp_t          o_rsp,
    input  logic [NUM_IRQ-1:0] i_irq,
    output logic               o_irq
);

    logic [NUM_IRQ-1:0] en_q;
    logic               word;
    logic               wr;

    // Word 0 mask, word 1 raw levels
    assign word = i_req.adr[2];
    assign wr   = i_sel && i_ack && i_req.we && !word;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            en_q <= '0;
        end else if (wr) begin
            en_q <= i_req.dat[NUM_IRQ-1:0];
        end
    end

    // One cycle behind the sources
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            o_irq <= 1'b0;
        end else begin
            o_irq <= |(i_irq & en_q);
        end
    end

    assign o_rsp.ack = i_ack;
    assign o_rsp.rdt = !i_ack ? '0
                     : word   ? bus_data_t'(i_irq)
                     :          bus_data_t'(en_q);

endmodule

// ==== source/ram_arb.sv ====
module ram_arb
    import soc_pkg::*;
(
    input  logic      ck,
    input  logic      RESET_LOOP,
    // Port A, data bus, priority master
    input  dbus_req_t i_a,
    output dbus_rsp_t o_a,
    // Port B, audio DMA
    input  dbus_req_t i_b,
    output dbus_rsp_t o_b,
    // Port X, toward the RAM
    output dbus_req_t o_x,
    input  dbus_rsp_t i_x
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GNT_A,
        ARB_GNT_B
    } arb_state_t;

    arb_state_t state;
    arb_state_t state_nxt;
    arb_state_t owner;

    // Grant is immediate when idle so an uncontended access has no extra cycle
    always_comb begin
        owner = state;
        if (state == ARB_IDLE) begin
            if (i_a.cyc) begin
                owner = ARB_GNT_A;
            end else if (i_b.cyc) begin
                owner = ARB_GNT_B;
            end
        end
    end

    // Hold the grant until the owner drops cyc
    // A waiting master takes over straight away so neither side starves
    always_comb begin
        state_nxt = state;
        case (state)
            ARB_IDLE:  state_nxt = owner;
            ARB_GNT_A: if (!i_a.cyc) state_nxt = i_b.cyc ? ARB_GNT_B : ARB_IDLE;
            ARB_GNT_B: if (!i_b.cyc) state_nxt = i_a.cyc ? ARB_GNT_A : ARB_IDLE;
            default:   state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Granted request to X, nothing otherwise
    always_comb begin
        o_x = '0;
        case (owner)
            ARB_GNT_A: o_x = i_a;
            ARB_GNT_B: o_x = i_b;
            default:   o_x = '0;
        endcase
    end

    // Response only to the owner, the loser sees zeros and keeps waiting
    assign o_a = (owner == ARB_GNT_A) ? i_x : '0;
    assign o_b = (owner == ARB_GNT_B) ? i_x : '0;

    // X stays quiet while idle, a RAM response always lands on a held grant
    a_idle_quiet: assert property (
        @(posedge ck) disable iff (RESET_LOOP)
        (state == ARB_IDLE) |-> !i_x.ack
    );

endmodule

// ==== source/soc_dbus.sv ====
`include "soc_cfg.svh"

module soc_dbus
    import soc_pkg::*;
(
    input  logic       ck,
    input  logic       RESET_LOOP,
    input  dbus_req_t  i_dbus,
    output dbus_rsp_t  o_dbus,
    input  dbus_req_t  i_dma,
    output dbus_rsp_t  o_dma,
    input  logic       i_ext_irq,
    output logic [7:0] o_gpio,
    output logic       o_irq
);

    dbus_req_t x_req;
    dbus_rsp_t x_rsp;
    dbus_rsp_t ram_rsp;
    dbus_rsp_t gpio_rsp;
    dbus_rsp_t timer_rsp;
    dbus_rsp_t irq_rsp;
    bus_data_t ram_rdt;
    logic      ram_sel, ram_ack;
    logic      gpio_sel, gpio_ack;
    logic      timer_sel, timer_ack;
    logic      irq_sel, irq_ack;
    logic      timer_irq;
    logic [`SOC_IRQ_SOURCES-1:0] irq_src;

    // RAM shared with the DMA port
    ram_arb arb (.ck, .RESET_LOOP, .i_a(i_dbus), .o_a(ram_rsp), .i_b(i_dma), .o_b(o_dma),
                 .o_x(x_req), .i_x(x_rsp));

    chip_select #(.ADDR(`SOC_RAM_ADDR)) cs_ram (.ck, .RESET_LOOP, .i_cyc(x_req.cyc),
        .i_dev(x_req.adr[31 -: `SOC_DEV_BITS]), .o_sel(ram_sel), .o_ack(ram_ack));

    sp_ram #(.WORDS(`SOC_RAM_WORDS)) ram (.ck, .i_sel(ram_sel), .i_req(x_req), .o_rdt(ram_rdt));

    assign x_rsp.ack = ram_ack;
    assign x_rsp.rdt = ram_ack ? ram_rdt : '0;

    // Peripherals decode straight off the data bus
    chip_select #(.ADDR(`SOC_GPIO_ADDR)) cs_gpio (.ck, .RESET_LOOP, .i_cyc(i_dbus.cyc),
        .i_dev(i_dbus.adr[31 -: `SOC_DEV_BITS]), .o_sel(gpio_sel), .o_ack(gpio_ack));
    chip_select #(.ADDR(`SOC_TIMER_ADDR)) cs_timer (.ck, .RESET_LOOP, .i_cyc(i_dbus.cyc),
        .i_dev(i_dbus.adr[31 -: `SOC_DEV_BITS]), .o_sel(timer_sel), .o_ack(timer_ack));
    chip_select #(.ADDR(`SOC_IRQ_ADDR)) cs_irq (.ck, .RESET_LOOP, .i_cyc(i_dbus.cyc),
        .i_dev(i_dbus.adr[31 -: `SOC_DEV_BITS]), .o_sel(irq_sel), .o_ack(irq_ack));

    gpio gpio_io (.ck, .RESET_LOOP, .i_sel(gpio_sel), .i_ack(gpio_ack), .i_req(i_dbus),
                  .o_rsp(gpio_rsp), .o_gpio);
    timer timer_io (.ck, .RESET_LOOP, .i_sel(timer_sel), .i_ack(timer_ack), .i_req(i_dbus),
                    .o_rsp(timer_rsp), .o_irq(timer_irq));

    // Timer at bit 0, external at bit 1
    assign irq_src = {i_ext_irq, timer_irq};

    irq_reg #(.NUM_IRQ(`SOC_IRQ_SOURCES)) irq_io (.ck, .RESET_LOOP, .i_sel(irq_sel),
        .i_ack(irq_ack), .i_req(i_dbus), .o_rsp(irq_rsp), .i_irq(irq_src), .o_irq);

    // Every target is zero unless acknowledging
    assign o_dbus.ack = ram_rsp.ack | gpio_rsp.ack | timer_rsp.ack | irq_rsp.ack;
    assign o_dbus.rdt = ram_rsp.rdt | gpio_rsp.rdt | timer_rsp.rdt | irq_rsp.rdt;

    a_one_target: assert property (
        @(posedge ck) disable iff (RESET_LOOP)
        $onehot0({ram_rsp.ack, gpio_rsp.ack, timer_rsp.ack, irq_rsp.ack})
    );

endmodule

// ==== source/soc_pkg.sv ====
`include "soc_cfg.svh"

package soc_pkg;

    // Byte address, top byte picks the device
    typedef logic [`SOC_ADDR_BITS-1:0] bus_addr_t;

    // One bus data word
    typedef logic [`SOC_DATA_BITS-1:0] bus_data_t;

    // Byte-lane enables, one per byte of a data word
    typedef logic [`SOC_DATA_BITS/8-1:0] bus_sel_t;

    // Device field of the address
    typedef logic [`SOC_DEV_BITS-1:0] dev_id_t;

    // Master to target
    typedef struct packed {
        logic      cyc;
        logic      we;
        bus_sel_t  sel;
        bus_addr_t adr;
        bus_data_t dat;
    } dbus_req_t;

    // Target to master, all zero when idle so responses can be ORed
    typedef struct packed {
        logic      ack;
        bus_data_t rdt;
    } dbus_rsp_t;

endpackage

// ==== source/sp_ram.sv ====
module sp_ram
    import soc_pkg::*;
#(
    parameter int WORDS = 256
) (
    input  logic      ck,
    input  logic      i_sel,
    input  dbus_req_t i_req,
    output bus_data_t o_rdt
);

    localparam int AW = $clog2(WORDS);
    localparam int LANES = $bits(bus_sel_t);

    bus_data_t     mem [WORDS];
    logic [AW-1:0] idx;

    // Word index sits above the byte offset
    assign idx = i_req.adr[AW+1:2];

    always_ff @(posedge ck) begin
        if (i_sel) begin
            if (i_req.we) begin
                for (int i = 0; i < LANES; i++) begin
                    if (i_req.sel[i]) begin
                        mem[idx][8*i +: 8] <= i_req.dat[8*i +: 8];
                    end
                end
            end else begin
                // Registered read, ready in the ack cycle
                o_rdt <= mem[idx];
            end
        end
    end

endmodule

// ==== source/timer.sv ====
module timer
    import soc_pkg::*;
(
    input  logic      ck,
    input  logic      RESET_LOOP,
    input  logic      i_sel,
    input  logic      i_ack,
    input  dbus_req_t i_req,
    output dbus_rsp_t o_rsp,
    output logic      o_irq
);

    // Word offsets
    localparam logic [1:0] W_TIME_LO = 2'd0;
    localparam logic [1:0] W_TIME_HI = 2'd1;
    localparam logic [1:0] W_CMP_LO  = 2'd2;
    localparam logic [1:0] W_CMP_HI  = 2'd3;

    logic [63:0] time_q;
    logic [63:0] cmp_q;
    logic [1:0]  word;
    logic        wr;
    bus_data_t   rd_word;

    assign word = i_req.adr[3:2];
    assign wr   = i_sel && i_ack && i_req.we;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            time_q <= '0;
            cmp_q  <= '1;
        end else begin
            // Bus write to time wins over the increment
            if (wr && word == W_TIME_LO) begin
                time_q[31:0] <= i_req.dat;
            end else if (wr && word == W_TIME_HI) begin
                time_q[63:32] <= i_req.dat;
            end else begin
                time_q <= time_q + 64'd1;
            end

            if (wr && word == W_CMP_LO) begin
                cmp_q[31:0] <= i_req.dat;
            end
            if (wr && word == W_CMP_HI) begin
                cmp_q[63:32] <= i_req.dat;
            end
        end
    end

    always_comb begin
        case (word)
            W_TIME_LO: rd_word = time_q[31:0];
            W_TIME_HI: rd_word = time_q[63:32];
            W_CMP_LO:  rd_word = cmp_q[31:0];
            default:   rd_word = cmp_q[63:32];
        endcase
    end

    assign o_rsp.ack = i_ack;
    assign o_rsp.rdt = i_ack ? rd_word : '0;

    // Level interrupt, as in the RISC-V machine timer
    assign o_irq = (time_q >= cmp_q);

endmodule

// ==== test/tb_soc_dbus.sv ====
`include "soc_cfg.svh"

module tb_soc_dbus
    import soc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // About 300 transactions of at most 10 cycles each, plus margin
    localparam int CYCLE_LIMIT = 4000;
    localparam int ACK_WAIT = 10;
    localparam bus_addr_t GPIO_BASE  = {`SOC_GPIO_ADDR, 24'h0};
    localparam bus_addr_t TIMER_BASE = {`SOC_TIMER_ADDR, 24'h0};
    localparam bus_addr_t IRQ_BASE   = {`SOC_IRQ_ADDR, 24'h0};
    localparam bus_addr_t NO_DEVICE  = {8'h10, 24'h0};

    // What a master expects back from one cycle
    typedef struct packed {
        logic      chk;
        bus_addr_t adr;
        bus_data_t val;
    } exp_t;

    logic       ck;
    logic       RESET_LOOP;
    dbus_req_t  dbus_req;
    dbus_rsp_t  dbus_rsp;
    dbus_req_t  dma_req;
    dbus_rsp_t  dma_rsp;
    logic       ext_irq;
    logic [7:0] gpio_out;
    logic       irq_out;

    bus_data_t ram_model [`SOC_RAM_WORDS];
    bus_data_t gpio_model;
    bus_data_t mask_model;
    exp_t      dbus_exp [$];
    exp_t      dma_exp [$];
    int        errors = 0;
    int        cycles = 0;
    bus_data_t dbus_rdt;
    int        dbus_waits;
    int        dma_waits;
    time       dbus_ack_t;
    time       dma_ack_t;

    soc_dbus soc_dbus_i (.ck, .RESET_LOOP, .i_dbus(dbus_req), .o_dbus(dbus_rsp),
                         .i_dma(dma_req), .o_dma(dma_rsp), .i_ext_irq(ext_irq),
                         .o_gpio(gpio_out), .o_irq(irq_out));

    always #10 ck = ~ck;

    // Word after a write, bytes with the lane off keep the old value
    function automatic bus_data_t merge_lanes(bus_data_t old, bus_data_t wdat, bus_sel_t sel);
        bus_data_t res;
        res = old;
        for (int i = 0; i < $bits(bus_sel_t); i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = wdat[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic fail_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input bus_data_t actual, input bus_data_t expected,
                               input string what);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR at %0d ns: %s, got %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    // Data bus master, holds the request until ack, drops cyc the cycle after
    task automatic dbus_access(input logic we, input bus_sel_t sel, input bus_addr_t adr,
                               input bus_data_t dat, input logic chk, input bus_data_t val);
        @(posedge ck);
        #1;
        dbus_exp.push_back('{chk: chk, adr: adr, val: val});
        dbus_req = '{cyc: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
        dbus_waits = 0;
        do begin
            @(posedge ck);
            #1;
            dbus_waits++;
            if (dbus_waits > ACK_WAIT) begin
                fail_run($sformatf("No acknowledge on the data bus for address %h", adr));
            end
        end while (!dbus_rsp.ack);
        dbus_rdt = dbus_rsp.rdt;
        dbus_ack_t = $time;
        @(posedge ck);
        #1;
        dbus_req = '0;
    endtask

    // DMA master, same handshake
    task automatic dma_access(input logic we, input bus_sel_t sel, input bus_addr_t adr,
                              input bus_data_t dat, input logic chk, input bus_data_t val);
        @(posedge ck);
        #1;
        dma_exp.push_back('{chk: chk, adr: adr, val: val});
        dma_req = '{cyc: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
        dma_waits = 0;
        do begin
            @(posedge ck);
            #1;
            dma_waits++;
            if (dma_waits > ACK_WAIT) begin
                fail_run($sformatf("No acknowledge on the DMA port for address %h", adr));
            end
        end while (!dma_rsp.ack);
        dma_ack_t = $time;
        @(posedge ck);
        #1;
        dma_req = '0;
    endtask

    task automatic ram_write(input logic use_dma, input int w, input bus_data_t dat,
                             input bus_sel_t sel);
        ram_model[w] = merge_lanes(ram_model[w], dat, sel);
        if (use_dma) begin
            dma_access(1'b1, sel, bus_addr_t'(w << 2), dat, 1'b0, '0);
        end else begin
            dbus_access(1'b1, sel, bus_addr_t'(w << 2), dat, 1'b0, '0);
        end
    endtask

    task automatic ram_read(input logic use_dma, input int w);
        if (use_dma) begin
            dma_access(1'b0, 4'hf, bus_addr_t'(w << 2), '0, 1'b1, ram_model[w]);
        end else begin
            dbus_access(1'b0, 4'hf, bus_addr_t'(w << 2), '0, 1'b1, ram_model[w]);
        end
    endtask

    // Compare every acknowledged cycle with what its master expected
    always begin
        exp_t e;
        @(posedge ck);
        #2;
        if (dbus_rsp.ack) begin
            if (dbus_exp.size() == 0) begin
                fail_run("The data bus was acknowledged with no cycle open");
            end else begin
                e = dbus_exp.pop_front();
                if (e.chk) begin
                    check_value(dbus_rsp.rdt, e.val, $sformatf("dbus read of %h", e.adr));
                end
            end
        end
        if (dma_rsp.ack) begin
            if (dma_exp.size() == 0) begin
                fail_run("The DMA port was acknowledged with no cycle open");
            end else begin
                e = dma_exp.pop_front();
                if (e.chk) begin
                    check_value(dma_rsp.rdt, e.val, $sformatf("DMA read of %h", e.adr));
                end
            end
        end
    end

    always @(posedge ck) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run("Timeout: the test did not finish within the cycle limit");
        end
    end

    initial begin
        int        seed;
        bus_data_t t0;
        bus_data_t t1;
        bus_data_t d;
        bus_data_t d2;
        bus_sel_t  s;
        logic      last_ext;
        seed = $urandom(80074);
        ck = 1'b0;
        RESET_LOOP = 1'b1;
        dbus_req = '0;
        dma_req = '0;
        ext_irq = 1'b0;
        gpio_model = '0;
        mask_model = '0;
        repeat (3) @(posedge ck);
        #1;
        RESET_LOOP = 1'b0;

        // RAM fill, random partial writes, read-back
        for (int i = 0; i < 32; i++) begin
            ram_write(1'b0, i, $urandom, 4'hf);
            check_value(32'(dbus_waits), 32'd1, "RAM write ack one cycle after cyc");
        end
        for (int i = 0; i < 64; i++) begin
            ram_write(1'b0, $urandom_range(31, 0), $urandom, bus_sel_t'($urandom_range(15, 1)));
            check_value(32'(dbus_waits), 32'd1, "RAM partial write ack one cycle after cyc");
        end
        for (int i = 0; i < 32; i++) begin
            ram_read(1'b0, i);
            check_value(32'(dbus_waits), 32'd1, "RAM read ack one cycle after cyc");
        end

        // DMA alone, then crossed read-back
        for (int i = 64; i < 80; i++) begin
            ram_write(1'b1, i, $urandom, 4'hf);
            check_value(32'(dma_waits), 32'd1, "uncontended DMA ack");
        end
        for (int i = 64; i < 80; i++) begin
            ram_read(1'b0, i);
        end
        for (int i = 96; i < 112; i++) begin
            ram_write(1'b0, i, $urandom, 4'hf);
        end
        for (int i = 96; i < 112; i++) begin
            ram_read(1'b1, i);
        end

        // Both masters in the same cycle, dbus has priority
        for (int i = 0; i < 8; i++) begin
            d = $urandom;
            d2 = $urandom;
            fork
                ram_write(1'b0, 128 + i, d, 4'hf);
                ram_write(1'b1, 160 + i, d2, 4'hf);
            join
            check_value(32'(dbus_ack_t < dma_ack_t), 32'd1, "dbus write acked before DMA");
        end
        for (int i = 0; i < 8; i++) begin
            fork
                ram_read(1'b0, 128 + i);
                ram_read(1'b1, 160 + i);
            join
            check_value(32'(dbus_ack_t < dma_ack_t), 32'd1, "dbus read acked before DMA");
        end

        // GPIO, only lane 0 reaches the pins
        for (int i = 0; i < 8; i++) begin
            d = $urandom;
            s = bus_sel_t'($urandom_range(15, 0));
            gpio_model = merge_lanes(gpio_model, d, s & 4'h1);
            dbus_access(1'b1, s, GPIO_BASE, d, 1'b0, '0);
            check_value(32'(gpio_out), gpio_model, "o_gpio after write");
            dbus_access(1'b0, 4'hf, GPIO_BASE, '0, 1'b1, gpio_model);
        end

        // Timer counts, interrupt off at compare all ones, on at zero
        dbus_access(1'b0, 4'hf, TIMER_BASE, '0, 1'b0, '0);
        t0 = dbus_rdt;
        dbus_access(1'b0, 4'hf, TIMER_BASE, '0, 1'b0, '0);
        t1 = dbus_rdt;
        check_value(32'(t1 > t0), 32'd1, "time low increases");
        dbus_access(1'b1, 4'hf, TIMER_BASE + 8, '1, 1'b0, '0);
        dbus_access(1'b1, 4'hf, TIMER_BASE + 12, '1, 1'b0, '0);
        dbus_access(1'b0, 4'hf, TIMER_BASE + 8, '0, 1'b1, '1);
        dbus_access(1'b0, 4'hf, IRQ_BASE + 4, '0, 1'b1, 32'd0);
        dbus_access(1'b1, 4'hf, TIMER_BASE + 8, '0, 1'b0, '0);
        dbus_access(1'b1, 4'hf, TIMER_BASE + 12, '0, 1'b0, '0);
        dbus_access(1'b0, 4'hf, TIMER_BASE + 12, '0, 1'b1, '0);
        dbus_access(1'b0, 4'hf, IRQ_BASE + 4, '0, 1'b1, 32'd1);

        // Enable mask read-back, then masked sources
        d = $urandom;
        mask_model = merge_lanes(mask_model, d, 4'hf) & 32'h3;
        dbus_access(1'b1, 4'hf, IRQ_BASE, d, 1'b0, '0);
        dbus_access(1'b0, 4'hf, IRQ_BASE, '0, 1'b1, mask_model);
        mask_model = merge_lanes(mask_model, '0, 4'hf) & 32'h3;
        dbus_access(1'b1, 4'hf, IRQ_BASE, '0, 1'b0, '0);
        for (int i = 0; i < 6; i++) begin
            @(posedge ck);
            #1;
            check_value(32'(irq_out), 32'd0, "o_irq with mask zero");
            ext_irq = ~ext_irq;
        end
        ext_irq = 1'b1;
        dbus_access(1'b0, 4'hf, IRQ_BASE + 4, '0, 1'b1, 32'd3);

        // Only the external source enabled
        mask_model = merge_lanes(mask_model, 32'd2, 4'hf) & 32'h3;
        dbus_access(1'b1, 4'hf, IRQ_BASE, 32'd2, 1'b0, '0);
        ext_irq = 1'b0;
        for (int i = 0; i < 12; i++) begin
            @(posedge ck);
            #1;
            // Level sampled on this edge, then a new one that must not show yet
            last_ext = ext_irq;
            ext_irq = 1'($urandom);
            #1;
            check_value(32'(irq_out), 32'(last_ext), "o_irq follows i_ext_irq a cycle later");
        end
        ext_irq = 1'b0;

        // Unmapped device, abandoned after 8 cycles
        @(posedge ck);
        #1;
        dbus_req = '{cyc: 1'b1, we: 1'b0, sel: 4'hf, adr: NO_DEVICE, dat: '0};
        repeat (8) begin
            @(posedge ck);
            #1;
            check_value(32'(dbus_rsp.ack), 32'd0, "ack from an unmapped address");
        end
        dbus_req = '0;
        ram_write(1'b0, 5, $urandom, 4'hf);
        ram_read(1'b0, 5);
        check_value(32'(dbus_waits), 32'd1, "RAM ack after an abandoned cycle");

        repeat (2) @(posedge ck);
        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            fail_run("One or more checks failed during the run");
        end
    end

endmodule
